// File: sdp_y_cvt_pkg.sv
// shared widths and serializer states; lane count and fifo depth are fixed here, not per instance
package sdp_y_cvt_pkg;

  // ========================================
  // datapath widths
  // ========================================

  // parallel converter lanes per vector
  localparam int lanes = 4;

  // lane index width, used for the output lane number
  localparam int lane_aw = $clog2(lanes);

  // one input element, signed
  localparam int in_dw = 16;

  // one converted element, signed and saturated
  localparam int out_dw = 32;

  // (element - offset) is out_dw+1 bits, times 16-bit scale
  localparam int mul_dw = 49;

  // ========================================
  // buffer sizing
  // ========================================

  // whole lane vectors held between converters and serializer
  localparam int fifo_depth = 4;

  // pointer width, depth must stay a power of two
  localparam int fifo_aw = $clog2(fifo_depth);

  // ========================================
  // serializer states
  // ========================================

  typedef enum logic [0:0] {
    ser_idle = 1'b0,
    ser_send = 1'b1
  } ser_state_t;

endpackage

// File: sdp_y_int_cvt.sv
// single lane, 2-cycle latency; cfg_* must be held static while data is in flight
`timescale 1ns/1ns

module sdp_y_int_cvt import sdp_y_cvt_pkg::*; (
  input  logic              nvdla_core_clk,
  input  logic              rst_n,
  input  logic              cfg_cvt_bypass,
  input  logic [31:0]       cfg_cvt_offset,
  input  logic [15:0]       cfg_cvt_scale,
  input  logic [5:0]        cfg_cvt_truncate,
  input  logic [in_dw-1:0]  cvt_data_in,
  input  logic              cvt_in_pvld,
  output logic              cvt_in_prdy,
  output logic              cvt_out_pvld,
  input  logic              cvt_out_prdy,
  output logic [out_dw-1:0] cvt_data_out
);

  // ========================================
  // stage 1: offset and scale
  // ========================================

  logic signed [out_dw:0]     sub_val;
  logic signed [mul_dw-1:0]   mul_val;
  logic signed [mul_dw-1:0]   byp_val;
  logic signed [mul_dw-1:0]   s1_data;
  logic                       s1_vld;

  // shared enable moves both stages together
  logic                       pipe_en;

  // one extra bit so element minus offset never wraps
  assign sub_val = $signed(cvt_data_in) - $signed(cfg_cvt_offset);
  assign mul_val = sub_val * $signed(cfg_cvt_scale);

  // bypass just sign-extends the element
  assign byp_val = $signed(cvt_data_in);

  // advance when stage 2 is free or being drained
  assign pipe_en     = !cvt_out_pvld || cvt_out_prdy;
  assign cvt_in_prdy = pipe_en;

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else if (pipe_en) begin
      s1_vld <= cvt_in_pvld;
    end
  end

  // stage 1 data register
  always_ff @(posedge nvdla_core_clk) begin
    if (pipe_en && cvt_in_pvld) begin
      s1_data <= cfg_cvt_bypass ? byp_val : mul_val;
    end
  end

  // ========================================
  // stage 2: round, shift, saturate
  // ========================================

  logic [5:0]                 trunc_m1;
  logic signed [mul_dw-1:0]   shr_m1;
  logic signed [mul_dw-1:0]   shr_val;
  logic signed [mul_dw-1:0]   rnd_val;
  logic [mul_dw-out_dw:0]     rnd_top;
  logic                       ovf;
  logic [out_dw-1:0]          sat_val;
  logic [out_dw-1:0]          s2_data;
  logic                       s2_vld;

  // shift one short first so the next bit out is the rounding bit
  // adding it equals adding half an lsb before the full shift
  assign trunc_m1 = cfg_cvt_truncate - 6'd1;
  assign shr_m1   = s1_data >>> trunc_m1;

  always_comb begin
    if (cfg_cvt_truncate == 6'd0) begin
      shr_val = s1_data;
      rnd_val = s1_data;
    end else begin
      shr_val = shr_m1 >>> 1;
      // shr_val has at least one bit of headroom here
      rnd_val = shr_val + $signed({{(mul_dw-1){1'b0}}, shr_m1[0]});
    end
  end

  // out of range when bits above the result sign differ
  assign rnd_top = rnd_val[mul_dw-1:out_dw-1];
  assign ovf     = !(&rnd_top) && (|rnd_top);

  always_comb begin
    if (!ovf) begin
      sat_val = rnd_val[out_dw-1:0];
    end else if (rnd_val[mul_dw-1]) begin
      // clamp to most negative
      sat_val = {1'b1, {(out_dw-1){1'b0}}};
    end else begin
      // clamp to most positive
      sat_val = {1'b0, {(out_dw-1){1'b1}}};
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      s2_vld <= 1'b0;
    end else if (pipe_en) begin
      s2_vld <= s1_vld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pipe_en && s1_vld) begin
      // bypass values already fit and skip rounding
      s2_data <= cfg_cvt_bypass ? s1_data[out_dw-1:0] : sat_val;
    end
  end

  assign cvt_out_pvld = s2_vld;
  assign cvt_data_out = s2_data;

endmodule

// File: sdp_y_cvt_fifo.sv
// fifo_depth must be a power of two; push when full is accepted only alongside a pop
`timescale 1ns/1ns

module sdp_y_cvt_fifo import sdp_y_cvt_pkg::*; (
  input  logic                    nvdla_core_clk,
  input  logic                    rst_n,
  input  logic                    push_pvld,
  output logic                    push_prdy,
  input  logic [lanes*out_dw-1:0] push_data,
  output logic                    pop_pvld,
  input  logic                    pop_prdy,
  output logic [lanes*out_dw-1:0] pop_data
);

  // ========================================
  // storage and pointers
  // ========================================

  logic [lanes*out_dw-1:0] mem [fifo_depth];
  logic [fifo_aw-1:0]      wr_ptr;
  logic [fifo_aw-1:0]      rd_ptr;
  logic [fifo_aw:0]        count;

  logic                    push_xfer;
  logic                    pop_xfer;
  logic                    full;

  assign full = (count == (fifo_aw+1)'(fifo_depth));

  // a pop in the same cycle frees the slot we write into
  assign push_prdy = !full || pop_prdy;
  assign pop_pvld  = (count != '0);
  assign pop_data  = mem[rd_ptr];

  assign push_xfer = push_pvld && push_prdy;
  assign pop_xfer  = pop_pvld && pop_prdy;

  // entry array, payload only
  always_ff @(posedge nvdla_core_clk) begin
    if (push_xfer) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ========================================
  // control
  // ========================================

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap naturally at power-of-two depth
      if (push_xfer) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_xfer) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // occupancy, unchanged on simultaneous push and pop
      if (push_xfer && !pop_xfer) begin
        count <= count + 1'b1;
      end else if (pop_xfer && !push_xfer) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: sdp_y_cvt_serializer.sv
// emits lanes 0..lanes-1 in order; a new vector loads only when idle or on the last beat
`timescale 1ns/1ns

module sdp_y_cvt_serializer import sdp_y_cvt_pkg::*; (
  input  logic                    nvdla_core_clk,
  input  logic                    rst_n,
  input  logic                    vec_pvld,
  output logic                    vec_prdy,
  input  logic [lanes*out_dw-1:0] vec_data,
  output logic                    cvt_out_pvld,
  input  logic                    cvt_out_prdy,
  output logic [out_dw-1:0]       cvt_out_data,
  output logic [1:0]              cvt_out_lane,
  output logic                    cvt_out_last
);

  ser_state_t              state;
  logic [lane_aw-1:0]      lane_cnt;
  logic [lanes*out_dw-1:0] vec_reg;

  logic                    beat_xfer;
  logic                    last_beat;
  logic                    vec_load;

  // ========================================
  // beat and load conditions
  // ========================================

  assign cvt_out_pvld = (state == ser_send);
  assign beat_xfer    = cvt_out_pvld && cvt_out_prdy;
  assign last_beat    = (lane_cnt == lane_aw'(lanes - 1));

  // take the next vector while the last lane goes out, no bubble
  assign vec_prdy = (state == ser_idle) || (beat_xfer && last_beat);
  assign vec_load = vec_pvld && vec_prdy;

  // ========================================
  // fsm and lane counter
  // ========================================

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      state    <= ser_idle;
      lane_cnt <= '0;
    end else if (vec_load) begin
      state    <= ser_send;
      lane_cnt <= '0;
    end else if (beat_xfer) begin
      if (last_beat) begin
        state <= ser_idle;
      end else begin
        lane_cnt <= lane_cnt + 1'b1;
      end
    end
  end

  // held vector, payload only
  always_ff @(posedge nvdla_core_clk) begin
    if (vec_load) begin
      vec_reg <= vec_data;
    end
  end

  // lane select from the held vector
  assign cvt_out_data = vec_reg[lane_cnt*out_dw +: out_dw];
  assign cvt_out_lane = lane_cnt;
  assign cvt_out_last = cvt_out_pvld && last_beat;

endmodule

// File: sdp_y_cvt_top.sv
// all lanes share config and handshake, lane 0 speaks for the group; cfg held static in flight
`timescale 1ns/1ns

module sdp_y_cvt_top import sdp_y_cvt_pkg::*; (
  input  logic                   nvdla_core_clk,
  input  logic                   rst_n,
  input  logic                   cfg_cvt_bypass,
  input  logic [31:0]            cfg_cvt_offset,
  input  logic [15:0]            cfg_cvt_scale,
  input  logic [5:0]             cfg_cvt_truncate,
  input  logic [lanes*in_dw-1:0] cvt_data_in,
  input  logic                   cvt_in_pvld,
  output logic                   cvt_in_prdy,
  output logic                   cvt_out_pvld,
  input  logic                   cvt_out_prdy,
  output logic [out_dw-1:0]      cvt_out_data,
  output logic [1:0]             cvt_out_lane,
  output logic                   cvt_out_last
);

  // ========================================
  // lane converters
  // ========================================

  logic [lanes*out_dw-1:0] lane_data;
  logic [lanes-1:0]        lane_in_prdy;
  logic [lanes-1:0]        lane_out_pvld;

  // fifo handshake back to the lanes
  logic                    fifo_push_prdy;
  logic                    fifo_pop_pvld;
  logic                    fifo_pop_prdy;
  logic [lanes*out_dw-1:0] fifo_pop_data;

  for (genvar i = 0; i < lanes; i++) begin : lane_cvt
    // every lane sees identical stalls, so they stay in lockstep
    sdp_y_int_cvt y_int_cvt (
      .nvdla_core_clk   (nvdla_core_clk),
      .rst_n            (rst_n),
      .cfg_cvt_bypass   (cfg_cvt_bypass),
      .cfg_cvt_offset   (cfg_cvt_offset),
      .cfg_cvt_scale    (cfg_cvt_scale),
      .cfg_cvt_truncate (cfg_cvt_truncate),
      .cvt_data_in      (cvt_data_in[i*in_dw +: in_dw]),
      .cvt_in_pvld      (cvt_in_pvld),
      .cvt_in_prdy      (lane_in_prdy[i]),
      .cvt_out_pvld     (lane_out_pvld[i]),
      .cvt_out_prdy     (fifo_push_prdy),
      .cvt_data_out     (lane_data[i*out_dw +: out_dw])
    );
  end

  // group handshake taken from lane 0
  assign cvt_in_prdy = lane_in_prdy[0];

  // ========================================
  // vector buffer and output serializer
  // ========================================

  sdp_y_cvt_fifo u_fifo (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .push_pvld      (lane_out_pvld[0]),
    .push_prdy      (fifo_push_prdy),
    .push_data      (lane_data),
    .pop_pvld       (fifo_pop_pvld),
    .pop_prdy       (fifo_pop_prdy),
    .pop_data       (fifo_pop_data)
  );

  sdp_y_cvt_serializer u_ser (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .vec_pvld       (fifo_pop_pvld),
    .vec_prdy       (fifo_pop_prdy),
    .vec_data       (fifo_pop_data),
    .cvt_out_pvld   (cvt_out_pvld),
    .cvt_out_prdy   (cvt_out_prdy),
    .cvt_out_data   (cvt_out_data),
    .cvt_out_lane   (cvt_out_lane),
    .cvt_out_last   (cvt_out_last)
  );

endmodule

// File: tb_sdp_y_cvt.sv
// run from the project root so cvt_input.txt is found; config only changes once the output drains
`timescale 1ns/1ns

module tb_sdp_y_cvt import sdp_y_cvt_pkg::*; ();

  localparam int clk_period = 10;
  localparam int wait_limit = 2000;
  localparam int lat_expect = 4;

  logic                   nvdla_core_clk;
  logic                   rst_n;
  logic                   cfg_cvt_bypass;
  logic [31:0]            cfg_cvt_offset;
  logic [15:0]            cfg_cvt_scale;
  logic [5:0]             cfg_cvt_truncate;
  logic [lanes*in_dw-1:0] cvt_data_in;
  logic                   cvt_in_pvld;
  logic                   cvt_in_prdy;
  logic                   cvt_out_pvld;
  logic                   cvt_out_prdy = 1'b1;
  logic [out_dw-1:0]      cvt_out_data;
  logic [1:0]             cvt_out_lane;
  logic                   cvt_out_last;

  // expected beats as {last, lane, data} queued by the driver for the monitor
  logic [34:0] exp_mem [0:1023];
  logic [34:0] exp_beat;
  int          wr_idx;
  int          rd_idx;
  int          mon_err;
  int          drv_err;
  int          beat_cnt;
  int          stall_cnt;
  int          cycle_cnt;
  int          lane0_cycle;

  // per-test bookkeeping
  int          bp_mode;
  logic [31:0] lfsr = 32'hff37;
  logic        abort;
  logic        in_test;
  string       test_name;
  int          test_err0;
  int          test_beat0;
  int          test_stall0;
  int          n_tests;
  int          n_fail;

  sdp_y_cvt_top dut_i (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever begin
      #(clk_period / 2) nvdla_core_clk = ~nvdla_core_clk;
    end
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // output ready is random only in back-pressure tests
  always @(negedge nvdla_core_clk) begin
    if (bp_mode == 1) begin
      lfsr = lfsr_next(lfsr);
      cvt_out_prdy = lfsr[0];
    end else begin
      cvt_out_prdy = 1'b1;
    end
  end

  // ========================================
  // output monitor
  // ========================================

  always @(posedge nvdla_core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_n && !cvt_in_prdy) begin
      stall_cnt = stall_cnt + 1;
    end
    if (rst_n && cvt_out_pvld && cvt_out_prdy) begin
      beat_cnt = beat_cnt + 1;
      if (cvt_out_lane == 2'd0) begin
        lane0_cycle = cycle_cnt;
      end
      assert (rd_idx != wr_idx) else begin
        $display("%0t ns: output beat arrived with nothing left to expect", $time);
        mon_err = mon_err + 1;
      end
      if (rd_idx != wr_idx) begin
        exp_beat = exp_mem[rd_idx];
        rd_idx = rd_idx + 1;
        assert (cvt_out_data === exp_beat[31:0]) else begin
          $display("** Error at %0t ns: cvt_out_data = %h, expected %h",
                   $time, cvt_out_data, exp_beat[31:0]);
          mon_err = mon_err + 1;
        end
        assert (cvt_out_lane === exp_beat[33:32]) else begin
          $display("** Error at %0t ns: cvt_out_lane = %0d, expected %0d",
                   $time, cvt_out_lane, exp_beat[33:32]);
          mon_err = mon_err + 1;
        end
        assert (cvt_out_last === exp_beat[34]) else begin
          $display("** Error at %0t ns: cvt_out_last = %b, expected %b",
                   $time, cvt_out_last, exp_beat[34]);
          mon_err = mon_err + 1;
        end
      end
    end
  end

  // ========================================
  // driver tasks
  // ========================================

  // starts on a falling edge and holds the vector until lane 0 takes it
  task automatic drive_vector(input logic [lanes*in_dw-1:0] data, output int xfer_cycle);
    int   waited;
    logic done;
    waited = 0;
    done = 1'b0;
    xfer_cycle = 0;
    cvt_data_in = data;
    cvt_in_pvld = 1'b1;
    while (!done && !abort) begin
      @(posedge nvdla_core_clk);
      if (cvt_in_prdy) begin
        done = 1'b1;
        xfer_cycle = cycle_cnt;
      end else if (waited == wait_limit) begin
        $display("timeout: cvt_in_prdy stayed low for %0d cycles", wait_limit);
        abort = 1'b1;
      end
      waited++;
    end
  endtask

  // stop input and wait for every queued beat
  task automatic drain_output();
    int         waited;
    ser_state_t st;
    waited = 0;
    @(negedge nvdla_core_clk);
    cvt_in_pvld = 1'b0;
    while (rd_idx != wr_idx && !abort) begin
      @(negedge nvdla_core_clk);
      if (waited == wait_limit) begin
        st = dut_i.u_ser.state;
        $display("timeout: %0d output beats never arrived, serializer in %s",
                 wr_idx - rd_idx, st.name());
        abort = 1'b1;
      end
      waited++;
    end
  endtask

  task automatic start_test(input string name, input int mode);
    test_name = name;
    bp_mode = mode;
    test_err0 = mon_err + drv_err;
    test_beat0 = beat_cnt;
    test_stall0 = stall_cnt;
    in_test = 1'b1;
  endtask

  task automatic finish_test();
    int errs;
    drain_output();
    if (bp_mode == 1 && !abort) begin
      assert (stall_cnt > test_stall0) else begin
        $display("cvt_in_prdy never fell during the back-pressure burst");
        drv_err++;
      end
    end
    errs = mon_err + drv_err - test_err0;
    $display("test %s: %0d beats, %0d errors", test_name, beat_cnt - test_beat0, errs);
    n_tests++;
    if (errs != 0 || abort) begin
      n_fail++;
    end
    in_test = 1'b0;
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    int                     fd;
    int                     n;
    int                     mode;
    int                     xfer_cycle;
    byte                    tag;
    string                  line;
    string                  name;
    logic                   byp;
    logic [31:0]            off;
    logic [15:0]            scl;
    logic [5:0]             trn;
    logic [15:0]            vin [lanes];
    logic [31:0]            vexp [lanes];
    logic [lanes*in_dw-1:0] packed_in;

    rst_n = 1'b0;
    cfg_cvt_bypass = 1'b0;
    cfg_cvt_offset = '0;
    cfg_cvt_scale = '0;
    cfg_cvt_truncate = '0;
    cvt_data_in = '0;
    cvt_in_pvld = 1'b0;
    abort = 1'b0;
    in_test = 1'b0;
    bp_mode = 0;
    repeat (16) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    rst_n = 1'b1;

    // idle outputs straight after reset
    start_test("reset", 0);
    @(negedge nvdla_core_clk);
    assert (cvt_out_pvld === 1'b0) else begin
      $display("** Error at %0t ns: cvt_out_pvld = %b, expected 0", $time, cvt_out_pvld);
      drv_err++;
    end
    assert (cvt_in_prdy === 1'b1) else begin
      $display("** Error at %0t ns: cvt_in_prdy = %b, expected 1", $time, cvt_in_prdy);
      drv_err++;
    end
    finish_test();

    fd = $fopen("cvt_input.txt", "r");
    if (fd == 0) begin
      $display("could not open cvt_input.txt");
      abort = 1'b1;
    end
    while (!abort && fd != 0 && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      tag = (line.len() > 0) ? line.getc(0) : "#";
      case (tag)
        "t": begin
          if (in_test) begin
            finish_test();
          end
          n = $sscanf(line, "t %d %s", mode, name);
          assert (n == 2) else begin
            $display("malformed test line in cvt_input.txt: %s", line);
            drv_err++;
          end
          start_test(name, mode);
        end
        "c": begin
          n = $sscanf(line, "c %h %h %h %h", byp, off, scl, trn);
          assert (n == 4) else begin
            $display("malformed config line in cvt_input.txt: %s", line);
            drv_err++;
          end
          // config only moves with the pipeline empty
          drain_output();
          cfg_cvt_bypass = byp;
          cfg_cvt_offset = off;
          cfg_cvt_scale = scl;
          cfg_cvt_truncate = trn;
        end
        "v": begin
          n = $sscanf(line, "v %h %h %h %h %h %h %h %h", vin[0], vin[1], vin[2], vin[3],
                      vexp[0], vexp[1], vexp[2], vexp[3]);
          assert (n == 8) else begin
            $display("malformed vector line in cvt_input.txt: %s", line);
            drv_err++;
          end
          // the monitor never runs on a falling edge
          @(negedge nvdla_core_clk);
          for (int j = 0; j < lanes; j++) begin
            packed_in[j*in_dw +: in_dw] = vin[j];
            exp_mem[wr_idx] = {(j == lanes - 1), 2'(j), vexp[j]};
            wr_idx++;
          end
          drive_vector(packed_in, xfer_cycle);
          if (bp_mode == 2) begin
            drain_output();
            assert (abort || lane0_cycle - xfer_cycle == lat_expect) else begin
              $display("** Error at %0t ns: cvt_out_pvld first beat latency = %0d, expected %0d",
                       $time, lane0_cycle - xfer_cycle,
                       lat_expect);
              drv_err++;
            end
          end
        end
        "#", "\n": begin
        end
        default: begin
          $display("unreadable line in cvt_input.txt: %s", line);
          drv_err++;
        end
      endcase
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (in_test) begin
      finish_test();
    end

    $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_fail, mon_err + drv_err);
    if (!abort && n_fail == 0 && mon_err + drv_err == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: cvt_input.txt
# t <mode> <name>: new test, mode 0 ready high, 1 random ready, 2 latency per vector
# c <bypass> <offset> <scale> <truncate>, v <in0..in3> <exp0..exp3>: all hex, lane 0 first
t 0 bypass
c 1 00000000 0000 00
v 0001 ffff 7fff 8000 00000001 ffffffff 00007fff ffff8000
v 1234 fedc 0000 8001 00001234 fffffedc 00000000 ffff8001
# offset, scale and truncate have no effect in bypass
c 1 00000010 0002 03
v 0005 fffb 4000 c000 00000005 fffffffb 00004000 ffffc000
t 0 arith
c 0 00000010 0003 00
v 0020 0000 fff0 7fff 00000030 ffffffd0 ffffffa0 00017fcd
v 0010 0011 8000 0100 00000000 00000003 fffe7fd0 000002d0
c 0 fffffff6 fffe 00
v 0005 fff6 fff0 0064 ffffffe2 00000000 0000000c ffffff24
# truncate 2, halves round toward plus infinity
c 0 00000000 0001 02
v 0005 0006 fffa fff9 00000001 00000002 ffffffff fffffffe
v 0007 0002 fffe 0000 00000002 00000001 00000000 00000000
c 0 00000064 fff9 04
v 0000 00c8 0064 006c 0000002c ffffffd4 00000000 fffffffd
t 0 saturate
c 0 80000000 7fff 00
v 0000 8000 7fff 1234 7fffffff 7fffffff 7fffffff 7fffffff
c 0 7fffffff 7fff 00
v 0000 8000 7fff 1234 80000000 80000000 80000000 80000000
# exact range edges next to one step past them
c 0 7fffffff 8000 0f
v 0000 0001 ffff 8000 7fffffff 7ffffffe 7fffffff 7fffffff
c 0 80000001 8000 0f
v 0000 0001 0002 ffff 80000001 80000000 80000000 80000002
t 1 backpressure
c 0 00000003 0005 00
v 0000 0001 0002 0003 fffffff1 fffffff6 fffffffb 00000000
v 0004 0005 0006 0007 00000005 0000000a 0000000f 00000014
v 0008 0009 000a 000b 00000019 0000001e 00000023 00000028
v 000c 000d 000e 000f 0000002d 00000032 00000037 0000003c
v 0010 0011 0012 0013 00000041 00000046 0000004b 00000050
v 0014 0015 0016 0017 00000055 0000005a 0000005f 00000064
v 0018 0019 001a 001b 00000069 0000006e 00000073 00000078
v 001c 001d 001e 001f 0000007d 00000082 00000087 0000008c
v 0020 0021 0022 0023 00000091 00000096 0000009b 000000a0
v fff0 fff1 fff2 fff3 ffffffa1 ffffffa6 ffffffab ffffffb0
t 2 latency
c 1 00000000 0000 00
v 0011 0022 0033 0044 00000011 00000022 00000033 00000044
v 8001 7ffe ff00 00ff ffff8001 00007ffe ffffff00 000000ff

// File: sdp_y_cvt_top.f
sdp_y_cvt_pkg.sv
sdp_y_int_cvt.sv
sdp_y_cvt_fifo.sv
sdp_y_cvt_serializer.sv
sdp_y_cvt_top.sv
tb_sdp_y_cvt.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the converter testbench with verilator from the project root
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert --top-module tb_sdp_y_cvt -f sdp_y_cvt_top.f; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_sdp_y_cvt)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qxF '*** TEST PASSED ***'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
